//--- vlog.f
+incdir+common
common/sramx_pkg.sv
common/cbus_pkg.sv
line_buffer/strobe_translator.sv
line_buffer/line_buffer.sv
design/burst_memory.sv
design/cached_memory_top.sv
testbench/tb_clock.sv
testbench/cached_memory_tb.sv

//--- Bender.yml
package:
  name: cached_memory

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/sramx_pkg.sv
      - common/cbus_pkg.sv
      - line_buffer/strobe_translator.sv
      - line_buffer/line_buffer.sv
      - design/burst_memory.sv
      - design/cached_memory_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/tb_clock.sv
      - testbench/cached_memory_tb.sv

//--- testbench/cached_memory_tb.sv
`default_nettype none

`include "cache_config.svh"

module cached_memory_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int line_bytes      = `LINE_WORDS * `BYTES_PER_WORD;
    localparam int cycles_per_test = 2 * `LINE_WORDS + 2 * `MEM_LATENCY + 20;

    logic               clk;
    logic               resetn;
    logic               sramx_req;
    logic               sramx_wr;
    sramx_pkg::addr_t   sramx_addr;
    sramx_pkg::size_t   sramx_size;
    sramx_pkg::word_t   sramx_wdata;
    logic               sramx_addr_ok;
    logic               sramx_data_ok;
    sramx_pkg::word_t   sramx_rdata;

    // stimulus table, one column per queue
    string              t_name[$];
    logic               t_wr[$];
    sramx_pkg::addr_t   t_addr[$];
    sramx_pkg::size_t   t_size[$];
    sramx_pkg::word_t   t_wdata[$];
    sramx_pkg::word_t   t_expect[$];
    logic               t_hit[$];

    // byte-level reference memory and the line it expects to be held
    sramx_pkg::byte_t   ref_mem [`MEM_WORDS * `BYTES_PER_WORD];
    logic               ref_valid;
    logic [31:0]        ref_tag;

    logic [31:0]        rng_state;
    logic               table_ready;
    int                 errors;
    int                 tests_run;

    tb_clock #(.period_ns(8)) clock_i (.clk(clk));

    cached_memory_top cached_memory_top_i (
        .clk            (clk),
        .resetn         (resetn),
        .sramx_req      (sramx_req),
        .sramx_wr       (sramx_wr),
        .sramx_addr     (sramx_addr),
        .sramx_size     (sramx_size),
        .sramx_wdata    (sramx_wdata),
        .sramx_addr_ok  (sramx_addr_ok),
        .sramx_data_ok  (sramx_data_ok),
        .sramx_rdata    (sramx_rdata)
    );

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [3:0] byte_mask(input logic [1:0] size, input logic [1:0] offset);
        case (size)
            2'd0: return 4'b0001 << offset;
            2'd1: return offset[1] ? 4'b1100 : 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    function automatic logic [31:0] ref_word(input sramx_pkg::addr_t addr);
        logic [31:0] w;
        int base;
        base = int'({addr[31:2], 2'b00});
        for (int j = 0; j < `BYTES_PER_WORD; j++) begin
            w[8*j +: 8] = ref_mem[base + j];
        end
        return w;
    endfunction

    // appends one entry and moves the reference model past it
    task automatic add_entry(input string name, input logic wr, input sramx_pkg::addr_t addr,
                             input sramx_pkg::size_t size);
        logic [3:0] mask;
        logic [31:0] wdata;
        logic [31:0] line_tag;
        int base;
        mask = byte_mask(size, addr[1:0]);
        wdata = wr ? next_random() : 32'h0;
        base = int'({addr[31:2], 2'b00});
        line_tag = addr / line_bytes;
        t_hit.push_back(ref_valid && ref_tag == line_tag);
        ref_valid = 1'b1;
        ref_tag = line_tag;
        if (wr) begin
            for (int j = 0; j < `BYTES_PER_WORD; j++) begin
                if (mask[j]) begin
                    ref_mem[base + j] = wdata[8*j +: 8];
                end
            end
        end
        t_name.push_back(name);
        t_wr.push_back(wr);
        t_addr.push_back(addr);
        t_size.push_back(size);
        t_wdata.push_back(wdata);
        t_expect.push_back(ref_word(addr));
    endtask

    task automatic build_table();
        logic [31:0] rnd;
        add_entry("rd_cold", 1'b0, 32'h044, sramx_pkg::size_word);
        add_entry("rd_hit", 1'b0, 32'h04c, sramx_pkg::size_word);
        add_entry("wr_byte", 1'b1, 32'h049, sramx_pkg::size_byte);
        add_entry("wr_half", 1'b1, 32'h04e, sramx_pkg::size_half);
        add_entry("wr_word", 1'b1, 32'h050, sramx_pkg::size_word);
        add_entry("rd_after_byte", 1'b0, 32'h048, sramx_pkg::size_word);
        add_entry("rd_after_half", 1'b0, 32'h04c, sramx_pkg::size_word);
        add_entry("rd_after_word", 1'b0, 32'h050, sramx_pkg::size_word);
        // dirty line goes back to memory here
        add_entry("wr_miss_evict", 1'b1, 32'h100, sramx_pkg::size_word);
        add_entry("wr_hit_last", 1'b1, 32'h13c, sramx_pkg::size_word);
        add_entry("rd_evicted", 1'b0, 32'h048, sramx_pkg::size_word);
        add_entry("rd_evicted_half", 1'b0, 32'h04c, sramx_pkg::size_word);
        // refill starts at word 6 and wraps past the end of the line
        add_entry("wr_miss_wrap", 1'b1, 32'h11a, sramx_pkg::size_half);
        add_entry("rd_merged", 1'b0, 32'h118, sramx_pkg::size_word);
        add_entry("rd_line_word0", 1'b0, 32'h100, sramx_pkg::size_word);
        add_entry("rd_line_last", 1'b0, 32'h13c, sramx_pkg::size_word);
        add_entry("rd_line_untouched", 1'b0, 32'h120, sramx_pkg::size_word);
        for (int i = 0; i < 24; i++) begin
            rnd = next_random();
            add_entry($sformatf("rand_%0d", i), rnd[31], rnd & 32'h0000_0c7c,
                      sramx_pkg::size_word);
        end
    endtask

    // drives entry i from 1 ns after an edge and returns 1 ns after an edge
    task automatic apply_entry(input int i, output sramx_pkg::word_t rdata, output logic was_hit);
        logic accepted;
        logic done;
        logic reopened;
        accepted = 1'b0;
        done = 1'b0;
        reopened = 1'b0;
        was_hit = 1'b0;
        rdata = '0;
        sramx_req = 1'b1;
        sramx_wr = t_wr[i];
        sramx_addr = t_addr[i];
        sramx_size = t_size[i];
        sramx_wdata = t_wdata[i];
        while (!accepted) begin
            @(negedge clk);
            if (sramx_addr_ok) begin
                accepted = 1'b1;
                if (sramx_data_ok) begin
                    was_hit = 1'b1;
                    done = 1'b1;
                    rdata = sramx_rdata;
                end
            end
            @(posedge clk);
            #1;
        end
        sramx_req = 1'b0;
        while (!done) begin
            @(negedge clk);
            // a pending miss holds the cpu off
            if (sramx_addr_ok) begin
                reopened = 1'b1;
            end
            if (sramx_data_ok) begin
                done = 1'b1;
                rdata = sramx_rdata;
            end
            @(posedge clk);
            #1;
        end
        if (reopened) begin
            $display("test %s: addr_ok was high while the miss was still being handled",
                     t_name[i]);
            errors++;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %08h, actual %08h", name, expected, actual);
            errors++;
        end else begin
            $display("ok     %s: %08h", name, actual);
        end
    endtask

    initial begin
        sramx_pkg::word_t rdata;
        logic was_hit;
        resetn = 1'b1;
        sramx_req = 1'b0;
        sramx_wr = 1'b0;
        sramx_addr = '0;
        sramx_size = sramx_pkg::size_word;
        sramx_wdata = '0;
        errors = 0;
        tests_run = 0;
        rng_state = 32'h9bb88e78;
        ref_valid = 1'b0;
        ref_tag = '0;
        table_ready = 1'b0;
        for (int i = 0; i < `MEM_WORDS * `BYTES_PER_WORD; i++) begin
            ref_mem[i] = '0;
        end
        build_table();
        table_ready = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        resetn = 1'b0;
        @(posedge clk);
        #1;
        for (int i = 0; i < t_name.size(); i++) begin
            apply_entry(i, rdata, was_hit);
            tests_run++;
            if (t_wr[i]) begin
                // writes return no data, so the hit flag is what gets compared
                check_value({t_name[i], "_hit"}, 32'(t_hit[i]), 32'(was_hit));
            end else begin
                if (was_hit !== t_hit[i]) begin
                    $display("test %s: data_ok timing shows a %s where a %s was expected",
                             t_name[i], was_hit ? "hit" : "miss", t_hit[i] ? "hit" : "miss");
                    errors++;
                end
                check_value(t_name[i], t_expect[i], rdata);
            end
        end
        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (table_ready);
        repeat (17 + t_name.size() * cycles_per_test) @(posedge clk);
        $display("timeout: no data_ok from DUT");
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
`default_nettype none

module tb_clock #(
    parameter int period_ns = 8
) (
    output logic clk
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

//--- design/cached_memory_top.sv
`default_nettype none

module cached_memory_top (
    input  wire logic               clk,
    input  wire logic               resetn,

    input  wire logic               sramx_req,
    input  wire logic               sramx_wr,
    input  wire sramx_pkg::addr_t   sramx_addr,
    input  wire sramx_pkg::size_t   sramx_size,
    input  wire sramx_pkg::word_t   sramx_wdata,
    output logic                    sramx_addr_ok,
    output logic                    sramx_data_ok,
    output sramx_pkg::word_t        sramx_rdata
);

    // burst bus between buffer and memory
    logic                   cbus_valid;
    logic                   cbus_is_write;
    cbus_pkg::cbus_order_t  cbus_order;
    sramx_pkg::addr_t       cbus_addr;
    sramx_pkg::word_t       cbus_wdata;
    logic                   cbus_okay;
    logic                   cbus_last;
    sramx_pkg::word_t       cbus_rdata;

    line_buffer line_buffer_i (
        .clk            (clk),
        .resetn         (resetn),
        .sramx_req      (sramx_req),
        .sramx_wr       (sramx_wr),
        .sramx_addr     (sramx_addr),
        .sramx_size     (sramx_size),
        .sramx_wdata    (sramx_wdata),
        .sramx_addr_ok  (sramx_addr_ok),
        .sramx_data_ok  (sramx_data_ok),
        .sramx_rdata    (sramx_rdata),
        .cbus_valid     (cbus_valid),
        .cbus_is_write  (cbus_is_write),
        .cbus_order     (cbus_order),
        .cbus_addr      (cbus_addr),
        .cbus_wdata     (cbus_wdata),
        .cbus_okay      (cbus_okay),
        .cbus_last      (cbus_last),
        .cbus_rdata     (cbus_rdata)
    );

    burst_memory burst_memory_i (
        .clk            (clk),
        .resetn         (resetn),
        .cbus_valid     (cbus_valid),
        .cbus_is_write  (cbus_is_write),
        .cbus_order     (cbus_order),
        .cbus_addr      (cbus_addr),
        .cbus_wdata     (cbus_wdata),
        .cbus_okay      (cbus_okay),
        .cbus_last      (cbus_last),
        .cbus_rdata     (cbus_rdata)
    );

endmodule

`default_nettype wire

//--- design/burst_memory.sv
`default_nettype none

`include "cache_config.svh"

module burst_memory (
    input  wire logic                   clk,
    input  wire logic                   resetn,

    input  wire logic                   cbus_valid,
    input  wire logic                   cbus_is_write,
    input  wire cbus_pkg::cbus_order_t  cbus_order,
    input  wire sramx_pkg::addr_t       cbus_addr,
    input  wire sramx_pkg::word_t       cbus_wdata,
    output logic                        cbus_okay,
    output logic                        cbus_last,
    output sramx_pkg::word_t            cbus_rdata
);

    localparam int idx_bits   = $clog2(`MEM_WORDS);
    localparam int align_bits = $clog2(`BYTES_PER_WORD);
    localparam int wait_bits  = $clog2(`MEM_LATENCY + 1);

    typedef logic [idx_bits-1:0]  idx_t;
    typedef logic [15:0]          beat_t;
    typedef logic [wait_bits-1:0] wait_t;

    typedef enum logic {
        m_idle,
        m_run
    } state_t;

    state_t             state;
    wait_t              wait_cnt;
    beat_t              beat_cnt;

    // burst parameters, taken when the burst starts
    logic               is_write;
    idx_t               start_idx;
    beat_t              last_cnt;

    idx_t               mask;
    idx_t               cur_idx;
    sramx_pkg::word_t   mem [`MEM_WORDS];

    initial begin
        for (int i = 0; i < `MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // word index wraps inside the aligned block
    assign mask    = idx_t'(last_cnt);
    assign cur_idx = (start_idx & ~mask) | ((start_idx + idx_t'(beat_cnt)) & mask);

    assign cbus_okay  = state == m_run && wait_cnt == '0;
    assign cbus_last  = cbus_okay && beat_cnt == last_cnt;
    assign cbus_rdata = mem[cur_idx];

    always_ff @(posedge clk) begin
        if (resetn) begin
            state    <= m_idle;
            wait_cnt <= '0;
            beat_cnt <= '0;
        end else begin
            unique case (state)
                m_idle: begin
                    if (cbus_valid) begin
                        state    <= m_run;
                        wait_cnt <= wait_t'(`MEM_LATENCY - 1);
                        beat_cnt <= '0;
                    end
                end
                m_run: begin
                    if (wait_cnt != '0) begin
                        wait_cnt <= wait_cnt - wait_t'(1);
                    end else if (cbus_last) begin
                        // back to idle so valid is sampled afresh
                        state <= m_idle;
                    end else begin
                        beat_cnt <= beat_cnt + beat_t'(1);
                    end
                end
                default: begin
                    state <= m_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == m_idle && cbus_valid) begin
            is_write  <= cbus_is_write;
            start_idx <= cbus_addr[align_bits +: idx_bits];
            last_cnt  <= (beat_t'(1) << cbus_order) - beat_t'(1);
        end

        if (cbus_okay && is_write) begin
            mem[cur_idx] <= cbus_wdata;
        end
    end

endmodule

`default_nettype wire

//--- line_buffer/line_buffer.sv
`default_nettype none

`include "cache_config.svh"

module line_buffer (
    input  wire logic                   clk,
    input  wire logic                   resetn,

    input  wire logic                   sramx_req,
    input  wire logic                   sramx_wr,
    input  wire sramx_pkg::addr_t       sramx_addr,
    input  wire sramx_pkg::size_t       sramx_size,
    input  wire sramx_pkg::word_t       sramx_wdata,
    output logic                        sramx_addr_ok,
    output logic                        sramx_data_ok,
    output sramx_pkg::word_t            sramx_rdata,

    output logic                        cbus_valid,
    output logic                        cbus_is_write,
    output cbus_pkg::cbus_order_t       cbus_order,
    output sramx_pkg::addr_t            cbus_addr,
    output sramx_pkg::word_t            cbus_wdata,
    input  wire logic                   cbus_okay,
    input  wire logic                   cbus_last,
    input  wire sramx_pkg::word_t       cbus_rdata
);

    localparam int offset_bits = $clog2(`LINE_WORDS);
    localparam int align_bits  = $clog2(`BYTES_PER_WORD);
    localparam int tag_bits    = $bits(sramx_pkg::addr_t) - offset_bits - align_bits;

    typedef logic [offset_bits-1:0] offset_t;
    typedef logic [align_bits-1:0]  align_t;
    typedef logic [tag_bits-1:0]    tag_t;

    typedef enum logic [1:0] {
        s_idle,
        s_read,
        s_write
    } state_t;

    // line state
    state_t             state;
    logic               valid;
    logic               dirty;
    tag_t               tag;
    offset_t            offset;
    sramx_pkg::word_t   line [`LINE_WORDS];

    // request held over a miss
    logic               saved_wr;
    sramx_pkg::addr_t   saved_addr;
    sramx_pkg::size_t   saved_size;
    sramx_pkg::word_t   saved_wdata;

    tag_t               req_tag;
    offset_t            req_offset;
    align_t             req_index;
    tag_t               saved_tag;
    offset_t            saved_offset;
    align_t             saved_index;
    sramx_pkg::strobe_t req_strb;
    sramx_pkg::strobe_t saved_strb;
    logic               tag_hit;
    logic               offset_hit;
    logic               hit;
    logic               miss;

    function automatic sramx_pkg::word_t merge_word(
        input sramx_pkg::word_t     old_word,
        input sramx_pkg::word_t     new_word,
        input sramx_pkg::strobe_t   strobe
    );
        sramx_pkg::byte_t [`BYTES_PER_WORD-1:0] old_bytes;
        sramx_pkg::byte_t [`BYTES_PER_WORD-1:0] new_bytes;
        sramx_pkg::byte_t [`BYTES_PER_WORD-1:0] merged;
        old_bytes = old_word;
        new_bytes = new_word;
        for (int j = 0; j < `BYTES_PER_WORD; j++) begin
            merged[j] = strobe[j] ? new_bytes[j] : old_bytes[j];
        end
        return sramx_pkg::word_t'(merged);
    endfunction

    assign {req_tag, req_offset, req_index}       = sramx_addr;
    assign {saved_tag, saved_offset, saved_index} = saved_addr;

    assign tag_hit    = valid && tag == req_tag;
    assign offset_hit = offset == saved_offset;
    assign hit        = state == s_idle && sramx_req && tag_hit;
    assign miss       = state == s_idle && sramx_req && !tag_hit;

    strobe_translator req_strb_i (
        .size   (sramx_size),
        .offset (req_index),
        .strobe (req_strb)
    );

    strobe_translator saved_strb_i (
        .size   (saved_size),
        .offset (saved_index),
        .strobe (saved_strb)
    );

    always_ff @(posedge clk) begin
        if (resetn) begin
            state  <= s_idle;
            valid  <= 1'b0;
            dirty  <= 1'b0;
            offset <= '0;
        end else begin
            unique case (state)
                s_idle: begin
                    if (hit && sramx_wr) begin
                        dirty <= 1'b1;
                    end else if (miss) begin
                        // write back first if the line holds unsaved data
                        if (dirty) begin
                            state  <= s_write;
                            offset <= '0;
                        end else begin
                            state  <= s_read;
                            offset <= req_offset;
                        end
                    end
                end
                s_read: begin
                    // offset wraps with the burst
                    if (cbus_okay) begin
                        offset <= offset + offset_t'(1);
                    end
                    if (cbus_last) begin
                        state <= s_idle;
                        valid <= 1'b1;
                        dirty <= saved_wr;
                        tag   <= saved_tag;
                    end
                end
                s_write: begin
                    if (cbus_last) begin
                        state  <= s_read;
                        offset <= saved_offset;
                    end else if (cbus_okay) begin
                        offset <= offset + offset_t'(1);
                    end
                end
                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (hit && sramx_wr) begin
            line[req_offset] <= merge_word(line[req_offset], sramx_wdata, req_strb);
        end else if (state == s_read && cbus_okay) begin
            // a saved write lands on top of its refill beat
            if (saved_wr && offset_hit) begin
                line[offset] <= merge_word(cbus_rdata, saved_wdata, saved_strb);
            end else begin
                line[offset] <= cbus_rdata;
            end
        end

        if (miss) begin
            saved_wr    <= sramx_wr;
            saved_addr  <= sramx_addr;
            saved_size  <= sramx_size;
            saved_wdata <= sramx_wdata;
        end
    end

    // cpu side
    assign sramx_addr_ok = state == s_idle;
    assign sramx_data_ok = hit || (state == s_read && cbus_okay && offset_hit);
    assign sramx_rdata   = state == s_idle ? line[req_offset] : cbus_rdata;

    // bus side
    assign cbus_valid    = state != s_idle;
    assign cbus_is_write = state == s_write;
    assign cbus_order    = cbus_pkg::cbus_order_t'(offset_bits);
    assign cbus_wdata    = line[offset];
    assign cbus_addr     = state == s_write ?
        {tag, offset_t'(0), align_t'(0)} :
        {saved_tag, saved_offset, align_t'(0)};

endmodule

`default_nettype wire

//--- line_buffer/strobe_translator.sv
`default_nettype none

module strobe_translator (
    input  wire sramx_pkg::size_t   size,
    input  wire logic [1:0]         offset,
    output sramx_pkg::strobe_t      strobe
);

    always_comb begin
        unique case (size)
            sramx_pkg::size_byte: begin
                strobe = sramx_pkg::strobe_t'(4'b0001 << offset);
            end
            sramx_pkg::size_half: begin
                // halfwords sit on even byte positions
                strobe = offset[1] ? 4'b1100 : 4'b0011;
            end
            sramx_pkg::size_word: begin
                strobe = 4'b1111;
            end
            default: begin
                strobe = 4'b1111;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- common/cbus_pkg.sv
`default_nettype none

package cbus_pkg;

    // burst length is 2 ** order beats
    typedef logic [3:0] cbus_order_t;

endpackage

`default_nettype wire

//--- common/sramx_pkg.sv
`default_nettype none

package sramx_pkg;

    // data word on the cpu port
    typedef logic [31:0] word_t;

    typedef logic [7:0] byte_t;

    // byte address, split into tag, word offset and byte index by the user
    typedef logic [31:0] addr_t;

    // access size code
    typedef logic [1:0] size_t;

    localparam size_t size_byte = 2'd0;
    localparam size_t size_half = 2'd1;
    localparam size_t size_word = 2'd2;

    // one enable bit per byte of a word
    typedef logic [3:0] strobe_t;

endpackage

`default_nettype wire

//--- common/cache_config.svh
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// words held by the single line
`define LINE_WORDS 16

// bytes in one bus word
`define BYTES_PER_WORD 4

// depth of the backing memory in words
`define MEM_WORDS 1024

// cycles from the start of a burst to its first beat, at least 1
`define MEM_LATENCY 2

`endif
